// File: Bender.yml
package:
  name: gnn_agg

sources:
  - files:
      - rtl/gnn_pkg.sv
      - rtl/gnn_ifs.sv
      - rtl/credit_fifo.sv
      - rtl/task_decoder.sv
      - rtl/edge_pe.sv
      - rtl/vertex_execute.sv
      - rtl/result_buffer.sv
      - rtl/gnn_top.sv
  - target: simulation
    files:
      - testbench/tb_gnn.sv

// File: rtl/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic push,
    input  payload_t  push_data,
    input  wire logic pop,
    output payload_t  pop_data,
    output logic      empty,
    output logic      credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];   // no reset on storage
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_pop;

    assign empty    = (count == '0);
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];   // head is visible the cycle after push
    assign credit   = do_pop;        // slot freed, hand it back upstream

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(do_pop);
        end
    end

    // upstream credit accounting must keep us from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count < DEPTH) || do_pop);

endmodule

`default_nettype wire

// File: rtl/edge_pe.sv
`timescale 1ns/1ps
`default_nettype none

module edge_pe #(
    parameter int PE_DEPTH = 4
) (
    input wire logic clk,
    input wire logic rst_n,
    edge_if.snk      beat_in,
    agg_if.src       agg_out
);
    import gnn_pkg::*;

    edge_beat_t in_beat;
    edge_beat_t head;
    logic       empty;
    logic       pop;
    logic       fire_last;   // popping the closing beat of a node
    agg_t       acc;         // running neighbor sum
    logic       agg_cred;    // single slot downstream

    assign in_beat = '{node: beat_in.node, feat: beat_in.feat, last: beat_in.last};

    credit_fifo #(.payload_t(edge_beat_t), .DEPTH(PE_DEPTH)) beat_fifo_u (
        .clk(clk), .rst_n(rst_n),
        .push(beat_in.valid), .push_data(in_beat),
        .pop(pop), .pop_data(head),
        .empty(empty), .credit(beat_in.credit)
    );

    // stall only on the last beat when downstream slot is busy
    assign pop       = !empty && (!head.last || agg_cred);
    assign fire_last = pop && head.last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc           <= '0;
            agg_cred      <= 1'b1;
            agg_out.valid <= 1'b0;
        end else begin
            agg_out.valid <= fire_last;   // one cycle after the last pop
            if (pop)
                acc <= fire_last ? '0 : acc + agg_t'(head.feat);   // clear for next node
            if (fire_last)
                agg_cred <= agg_out.credit;
            else if (agg_out.credit)
                agg_cred <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_last) begin
            agg_out.node <= head.node;
            agg_out.sum  <= acc + agg_t'(head.feat);   // include the closing feature
        end
    end

endmodule

`default_nettype wire

// File: rtl/gnn_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decoder -> edge pe beat link
interface edge_if;
    import gnn_pkg::*;

    logic     valid;
    node_id_t node;
    feat_t    feat;
    logic     last;
    logic     credit;   // one pulse per popped beat

    modport src (output valid, node, feat, last, input credit);
    modport snk (input valid, node, feat, last, output credit);
endinterface

// sum link, also reused for the result link
interface agg_if;
    import gnn_pkg::*;

    logic     valid;
    node_id_t node;
    agg_t     sum;      // carries res_val_t on the result link
    logic     credit;

    modport src (output valid, node, sum, input credit);
    modport snk (input valid, node, sum, output credit);
endinterface

`default_nettype wire

// File: rtl/gnn_pkg.sv
`default_nettype none

package gnn_pkg;

    typedef logic [7:0] node_id_t;          // node identifier
    typedef logic signed [7:0] feat_t;      // one neighbor feature
    typedef logic signed [15:0] agg_t;      // neighbor sum, holds 256 beats of feat_t
    typedef logic signed [7:0] weight_t;    // shared layer weight
    typedef logic [15:0] res_val_t;         // post-relu value, never negative

    // one beat of the edge stream, 17 bits
    typedef struct packed {
        node_id_t node;
        feat_t    feat;
        logic     last;    // closes the neighbor list
    } edge_beat_t;

    // finished sum from an edge pe
    typedef struct packed {
        node_id_t node;
        agg_t     sum;
    } agg_pkt_t;

    // final (node, value) pair
    typedef struct packed {
        node_id_t node;
        res_val_t value;
    } res_pkt_t;

    localparam int res_max = 32767;   // upper clip for 16 bit signed range

endpackage

`default_nettype wire

// File: rtl/gnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module gnn_top #(
    parameter int NUM_EDGE_PE = 4,
    parameter int IN_DEPTH    = 4,
    parameter int PE_DEPTH    = 4,
    parameter int RES_DEPTH   = 4
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          in_valid,
    input  gnn_pkg::node_id_t  in_node,
    input  gnn_pkg::feat_t     in_feat,
    input  wire logic          in_last,
    output logic               in_credit,
    input  gnn_pkg::weight_t   weight,      // held stable for the run
    output logic               out_valid,
    output gnn_pkg::node_id_t  out_node,
    output gnn_pkg::res_val_t  out_value,
    input  wire logic          out_credit
);

    edge_if pe_link  [NUM_EDGE_PE] ();   // decoder to edge pes
    agg_if  agg_link [NUM_EDGE_PE] ();   // edge pes to vertex unit
    agg_if  res_link ();                 // vertex unit to result buffer

    task_decoder #(
        .NUM_EDGE_PE(NUM_EDGE_PE), .IN_DEPTH(IN_DEPTH), .PE_DEPTH(PE_DEPTH)
    ) task_decoder_u (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_node(in_node), .in_feat(in_feat), .in_last(in_last),
        .in_credit(in_credit),
        .pe_out(pe_link)
    );

    for (genvar g = 0; g < NUM_EDGE_PE; g++) begin : g_edge_pe
        edge_pe #(.PE_DEPTH(PE_DEPTH)) edge_pe_u (
            .clk(clk), .rst_n(rst_n),
            .beat_in(pe_link[g]),
            .agg_out(agg_link[g])
        );
    end

    vertex_execute #(.NUM_EDGE_PE(NUM_EDGE_PE), .RES_DEPTH(RES_DEPTH)) vertex_execute_u (
        .clk(clk), .rst_n(rst_n),
        .weight(weight),
        .agg_in(agg_link),
        .res_out(res_link)
    );

    result_buffer #(.RES_DEPTH(RES_DEPTH)) result_buffer_u (
        .clk(clk), .rst_n(rst_n),
        .res_in(res_link),
        .out_valid(out_valid), .out_node(out_node), .out_value(out_value),
        .out_credit(out_credit)
    );

endmodule

`default_nettype wire

// File: rtl/result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module result_buffer #(
    parameter int RES_DEPTH = 4
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    agg_if.snk                 res_in,
    output logic               out_valid,
    output gnn_pkg::node_id_t  out_node,
    output gnn_pkg::res_val_t  out_value,
    input  wire logic          out_credit
);
    import gnn_pkg::*;

    localparam int CW = $clog2(RES_DEPTH + 1);

    res_pkt_t      in_pkt;
    res_pkt_t      head;
    logic          empty;
    logic          pop;
    logic [CW-1:0] out_cnt;   // sink credits left

    assign in_pkt = '{node: res_in.node, value: res_val_t'(res_in.sum)};

    credit_fifo #(.payload_t(res_pkt_t), .DEPTH(RES_DEPTH)) res_fifo_u (
        .clk(clk), .rst_n(rst_n),
        .push(res_in.valid), .push_data(in_pkt),
        .pop(pop), .pop_data(head),
        .empty(empty), .credit(res_in.credit)
    );

    assign pop       = !empty && (out_cnt != '0);   // send head while sink has room
    assign out_valid = pop;
    assign out_node  = head.node;
    assign out_value = head.value;

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_cnt <= CW'(RES_DEPTH);
        else
            out_cnt <= out_cnt - CW'(pop) + CW'(out_credit);
    end

    // sink must never hand back more credits than it was given
    a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        out_cnt <= RES_DEPTH);

endmodule

`default_nettype wire

// File: rtl/task_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module task_decoder #(
    parameter int NUM_EDGE_PE = 4,
    parameter int IN_DEPTH    = 4,
    parameter int PE_DEPTH    = 4
) (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         in_valid,
    input  gnn_pkg::node_id_t in_node,
    input  gnn_pkg::feat_t    in_feat,
    input  wire logic         in_last,
    output logic              in_credit,
    edge_if.src               pe_out [NUM_EDGE_PE]
);
    import gnn_pkg::*;

    localparam int PW = (NUM_EDGE_PE > 1) ? $clog2(NUM_EDGE_PE) : 1;
    localparam int CW = $clog2(PE_DEPTH + 1);

    edge_beat_t             in_beat;
    edge_beat_t             head;
    logic                   empty;
    logic                   send;
    logic [PW-1:0]          cur_pe;        // pe owning the current node
    logic [CW-1:0]          pe_cnt [NUM_EDGE_PE];
    logic [NUM_EDGE_PE-1:0] sent;
    logic [NUM_EDGE_PE-1:0] cred_ret;

    assign in_beat = '{node: in_node, feat: in_feat, last: in_last};

    credit_fifo #(.payload_t(edge_beat_t), .DEPTH(IN_DEPTH)) in_fifo_u (
        .clk(clk), .rst_n(rst_n),
        .push(in_valid), .push_data(in_beat),
        .pop(send), .pop_data(head),
        .empty(empty), .credit(in_credit)   // in_credit pulses on dispatch
    );

    assign send = !empty && (pe_cnt[cur_pe] != '0);   // head waits on zero credit

    for (genvar g = 0; g < NUM_EDGE_PE; g++) begin : g_pe
        assign sent[g]         = send && (cur_pe == PW'(g));
        assign pe_out[g].valid = sent[g];
        assign pe_out[g].node  = head.node;   // payload broadcast, valid selects
        assign pe_out[g].feat  = head.feat;
        assign pe_out[g].last  = head.last;
        assign cred_ret[g]     = pe_out[g].credit;

        // a pe only returns credit for a beat it holds, so a zero count means no room
        a_cred_bound: assert property (@(posedge clk) disable iff (!rst_n)
            cred_ret[g] |-> pe_cnt[g] < CW'(PE_DEPTH));
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_pe <= '0;   // first node goes to pe 0
            for (int k = 0; k < NUM_EDGE_PE; k++)
                pe_cnt[k] <= CW'(PE_DEPTH);
        end else begin
            if (send && head.last)
                cur_pe <= (cur_pe == PW'(NUM_EDGE_PE - 1)) ? '0 : cur_pe + 1'b1;
            for (int k = 0; k < NUM_EDGE_PE; k++)
                pe_cnt[k] <= pe_cnt[k] - CW'(sent[k]) + CW'(cred_ret[k]);
        end
    end

endmodule

`default_nettype wire

// File: rtl/vertex_execute.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_execute #(
    parameter int NUM_EDGE_PE = 4,
    parameter int RES_DEPTH   = 4
) (
    input wire logic        clk,
    input wire logic        rst_n,
    input gnn_pkg::weight_t weight,
    agg_if.snk              agg_in [NUM_EDGE_PE],
    agg_if.src              res_out
);
    import gnn_pkg::*;

    localparam int PW  = (NUM_EDGE_PE > 1) ? $clog2(NUM_EDGE_PE) : 1;
    localparam int RCW = $clog2(RES_DEPTH + 1);

    logic [NUM_EDGE_PE-1:0] in_valid;
    agg_pkt_t               in_pkt [NUM_EDGE_PE];
    logic [NUM_EDGE_PE-1:0] slot_valid;
    agg_pkt_t               slot [NUM_EDGE_PE];   // one entry per pe
    logic [PW-1:0]          rr_ptr;
    logic [PW-1:0]          pick_idx;
    logic                   found;
    logic                   take;
    logic [RCW-1:0]         res_cred;
    logic                   s1_valid;
    node_id_t               s1_node;
    logic signed [23:0]     s1_prod;              // 16x8 signed product
    res_val_t               sat_val;

    for (genvar g = 0; g < NUM_EDGE_PE; g++) begin : g_slot
        assign in_valid[g]      = agg_in[g].valid;
        assign in_pkt[g]        = '{node: agg_in[g].node, sum: agg_in[g].sum};
        assign agg_in[g].credit = take && (pick_idx == PW'(g));   // slot freed
    end

    // first full slot at or after rr_ptr
    always_comb begin
        int idx;
        found    = 1'b0;
        pick_idx = rr_ptr;
        for (int k = 0; k < NUM_EDGE_PE; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_EDGE_PE;
            if (!found && slot_valid[idx]) begin
                found    = 1'b1;
                pick_idx = PW'(idx);
            end
        end
    end

    assign take = found && (res_cred != '0);   // hold pick without result credit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= '0;
            rr_ptr     <= '0;
            res_cred   <= RCW'(RES_DEPTH);
            s1_valid   <= 1'b0;
            res_out.valid <= 1'b0;
        end else begin
            for (int k = 0; k < NUM_EDGE_PE; k++) begin
                if (in_valid[k])
                    slot_valid[k] <= 1'b1;
                else if (take && pick_idx == PW'(k))
                    slot_valid[k] <= 1'b0;
            end
            if (take)
                rr_ptr <= (pick_idx == PW'(NUM_EDGE_PE - 1)) ? '0 : pick_idx + 1'b1;
            res_cred      <= res_cred - RCW'(take) + RCW'(res_out.credit);
            s1_valid      <= take;
            res_out.valid <= s1_valid;
        end
    end

    // relu then clip to 16 bit positive range
    always_comb begin
        if (s1_prod < 0)
            sat_val = '0;
        else if (s1_prod > res_max)
            sat_val = res_val_t'(res_max);
        else
            sat_val = res_val_t'(s1_prod);
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_EDGE_PE; k++) begin
            if (in_valid[k])
                slot[k] <= in_pkt[k];
        end
        s1_node      <= slot[pick_idx].node;       // stage one, multiply
        s1_prod      <= slot[pick_idx].sum * weight;
        res_out.node <= s1_node;                   // stage two, relu and saturate
        res_out.sum  <= agg_t'(sat_val);
    end

endmodule

`default_nettype wire

// File: src.f
rtl/gnn_pkg.sv
rtl/gnn_ifs.sv
rtl/credit_fifo.sv
rtl/task_decoder.sv
rtl/edge_pe.sv
rtl/vertex_execute.sv
rtl/result_buffer.sv
rtl/gnn_top.sv
testbench/tb_gnn.sv

// File: testbench/gnn_vectors.txt
// first word weight, second word record count, then one record per line
// record is node_feature_last, node and signed feature as 8 bit hex, last as one digit
00064
00012
01_05_1
02_ec_0
02_e2_1
03_7f_0
03_7f_0
03_7f_1
04_0a_0
04_f6_0
04_03_1
05_40_1
06_01_0
06_02_0
06_03_0
06_04_0
06_05_1
07_80_1
08_11_0
08_22_1

// File: testbench/tb_gnn.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gnn;
    import gnn_pkg::*;

    localparam int IN_DEPTH    = 4;      // matches dut defaults
    localparam int RES_DEPTH   = 4;
    localparam int WAIT_LIMIT  = 1000;   // cycles per wait loop
    localparam int HOLD_CYCLES = 200;    // sink holds its credits this long

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    node_id_t in_node;
    feat_t    in_feat;
    logic     in_last;
    logic     in_credit;
    weight_t  weight;
    logic     out_valid;
    node_id_t out_node;
    res_val_t out_value;
    logic     out_credit;

    logic [19:0] vec [20];   // weight, record count, 18 records
    int exp_val [256];
    bit exp_has [256];
    bit got [256];
    int n_exp;               // nodes closed by a last beat
    int sent_cnt;            // beats driven
    int ret_cnt;             // in_credit pulses seen
    int res_cnt;             // out_valid pulses seen
    int granted;             // out_credit pulses seen at the dut
    int given;               // out_credit pulses driven by the sink
    int err_cnt;
    bit timed_out;

    gnn_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_node(in_node), .in_feat(in_feat), .in_last(in_last),
        .in_credit(in_credit),
        .weight(weight),
        .out_valid(out_valid), .out_node(out_node), .out_value(out_value),
        .out_credit(out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // relu of the weighted sum, clipped to the positive 16 bit limit
    function automatic int expected_value(input int sum, input int w);
        int p;
        p = sum * w;
        if (p < 0)
            return 0;
        if (p > 32767)
            return 32767;
        return p;
    endfunction

    task automatic build_expected(input int n_rec);
        int sum;
        int node;
        sum = 0;
        for (int i = 0; i < n_rec; i++) begin
            node = vec[i + 2][19:12];
            sum += $signed(vec[i + 2][11:4]);   // feature is signed
            if (vec[i + 2][3:0] != 4'h0) begin   // node closed
                exp_val[node] = expected_value(sum, weight);
                exp_has[node] = 1'b1;
                n_exp++;
                sum = 0;
            end
        end
    endtask

    task automatic check_result(input node_id_t node, input res_val_t value);
        if (!exp_has[node]) begin
            $display("result arrived for unknown node id %0d", node);
            err_cnt++;
        end else if (got[node]) begin
            $display("node %0d returned a second result", node);
            err_cnt++;
        end else begin
            got[node] = 1'b1;
            if (value !== res_val_t'(exp_val[node])) begin
                $display("Error: result_value node %0d expected %0d actual %0d",
                         node, exp_val[node], value);
                err_cnt++;
            end
        end
    endtask

    // sampled at posedge, all watched outputs come from flops
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                if (ret_cnt >= sent_cnt) begin
                    $display("in_credit pulsed with no beat outstanding");
                    err_cnt++;
                end
                ret_cnt++;
            end
            if (out_valid) begin
                if (res_cnt >= RES_DEPTH + granted) begin   // credit from this edge not yet usable
                    $display("out_valid pulsed without an output credit");
                    err_cnt++;
                end
                res_cnt++;
                check_result(out_node, out_value);
            end
            if (out_credit)
                granted++;
        end
    end

    // sink holds credits back first, then returns them after random delays
    initial begin
        int delay;
        out_credit = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
        forever begin
            @(negedge clk);
            out_credit = 1'b0;
            if (given < res_cnt) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge clk);
                out_credit = 1'b1;
                given++;
            end
        end
    end

    initial begin
        int seed_val;
        int n_rec;
        int gap;
        int waited;
        seed_val  = $urandom(32'h5ec5);
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_node   = '0;
        in_feat   = '0;
        in_last   = 1'b0;
        weight    = '0;
        err_cnt   = 0;
        n_exp     = 0;
        sent_cnt  = 0;
        ret_cnt   = 0;
        res_cnt   = 0;
        granted   = 0;
        given     = 0;
        timed_out = 1'b0;
        $readmemh("testbench/gnn_vectors.txt", vec);
        weight = weight_t'(vec[0][7:0]);   // stable for the whole run
        n_rec  = int'(vec[1]);
        build_expected(n_rec);
        repeat (3) @(negedge clk);   // three posedges in reset
        rst_n = 1'b1;
        for (int i = 0; i < n_rec && !timed_out; i++) begin
            gap = $urandom % 3;   // idle gap
            repeat (gap) @(negedge clk);
            waited = 0;
            while (sent_cnt - ret_cnt >= IN_DEPTH && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= WAIT_LIMIT) begin
                $display("timeout waiting for an input credit at beat %0d", i);
                err_cnt++;
                timed_out = 1'b1;
            end else begin
                in_valid = 1'b1;
                in_node  = vec[i + 2][19:12];
                in_feat  = vec[i + 2][11:4];
                in_last  = (vec[i + 2][3:0] != 4'h0);
                sent_cnt++;   // one credit spent
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        waited = 0;
        while (!timed_out && (res_cnt < n_exp || ret_cnt < sent_cnt)
               && waited < 2 * WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 2 * WAIT_LIMIT) begin
            $display("timeout waiting for the dut to drain");
            err_cnt++;
        end
        repeat (10) @(negedge clk);   // catch late extra pulses
        if (ret_cnt != sent_cnt) begin
            $display("Error: in_credit_total expected %0d actual %0d", sent_cnt, ret_cnt);
            err_cnt++;
        end
        if (res_cnt != n_exp) begin
            $display("Error: result_count expected %0d actual %0d", n_exp, res_cnt);
            err_cnt++;
        end
        for (int n = 0; n < 256; n++) begin
            if (exp_has[n] && !got[n]) begin
                $display("node %0d never returned a result", n);
                err_cnt++;
            end
        end
        $display("errors %0d, beats %0d, in credits %0d, results %0d, out credits %0d",
                 err_cnt, sent_cnt, ret_cnt, res_cnt, given);
        if (err_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
